//--- cpu_controller.sv
`timescale 1ns/100ps

module cpu_controller import cpu_pkg::*; (
  input  logic [WORD-1:0]       instr_i,
  output ctrl_t                 ctrl_o,
  output logic [ADDR_WIDTH-1:0] rs1_o,
  output logic [ADDR_WIDTH-1:0] rs2_o,
  output logic [ADDR_WIDTH-1:0] rd_o,
  output logic                  uses_rs2_o,
  output logic [WORD-1:0]       imm_o
);

  ////////////////////
  // field split
  ////////////////////

  opcode_e               opcode;
  logic [ADDR_WIDTH-1:0] rd_field;
  logic [ADDR_WIDTH-1:0] rs1_field;
  logic [ADDR_WIDTH-1:0] rs2_field;
  logic [IMM_WIDTH-1:0]  imm_field;

  assign opcode    = opcode_e'(instr_i[15:12]);
  assign rd_field  = instr_i[11:9];
  assign rs1_field = instr_i[8:6];
  assign rs2_field = instr_i[5:3];
  // imm overlaps rs2, only one of them is meaningful per opcode
  assign imm_field = instr_i[IMM_WIDTH-1:0];

  assign rd_o  = rd_field;
  assign rs1_o = rs1_field;
  // store data register is named by the rd field
  assign rs2_o = (opcode == STORE) ? rd_field : rs2_field;

  assign imm_o = {{(WORD-IMM_WIDTH){imm_field[IMM_WIDTH-1]}}, imm_field};

  ////////////////////
  // control decode
  ////////////////////

  always_comb begin
    // nop and unknown codes fall through with every enable low
    ctrl_o.alu_op      = ALU_ADD;
    ctrl_o.alu_src_imm = 1'b0;
    ctrl_o.mem_rd      = 1'b0;
    ctrl_o.mem_wr      = 1'b0;
    ctrl_o.reg_wr      = 1'b0;
    ctrl_o.wb_src      = WB_ALU;
    uses_rs2_o         = 1'b0;

    case (opcode)
      ADD, SUB, AND, OR, XOR: begin
        ctrl_o.reg_wr = 1'b1;
        uses_rs2_o    = 1'b1;
        case (opcode)
          SUB:     ctrl_o.alu_op = ALU_SUB;
          AND:     ctrl_o.alu_op = ALU_AND;
          OR:      ctrl_o.alu_op = ALU_OR;
          XOR:     ctrl_o.alu_op = ALU_XOR;
          default: ctrl_o.alu_op = ALU_ADD;
        endcase
      end
      ADDI: begin
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.reg_wr      = 1'b1;
      end
      LOAD: begin
        // address is rs1 + imm, result comes back from memory
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.mem_rd      = 1'b1;
        ctrl_o.reg_wr      = 1'b1;
        ctrl_o.wb_src      = WB_MEM;
      end
      STORE: begin
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.mem_wr      = 1'b1;
        uses_rs2_o         = 1'b1;
      end
      default: begin
        ctrl_o.alu_op = ALU_ADD;
      end
    endcase
  end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data and instruction width
  localparam int WORD       = 16;
  localparam int ADDR_WIDTH = 3;
  localparam int NUM_REGS   = 8;
  // immediate field sits in the low bits of the instruction
  localparam int IMM_WIDTH  = 6;

  ////////////////////
  // encodings
  ////////////////////

  // opcode lives in instr[15:12]
  typedef enum logic [3:0] {
    NOP   = 4'h0,
    ADD   = 4'h1,
    SUB   = 4'h2,
    AND   = 4'h3,
    OR    = 4'h4,
    XOR   = 4'h5,
    ADDI  = 4'h6,
    LOAD  = 4'h7,
    STORE = 4'h8
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // write-back source select
  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_src_e;

  ////////////////////
  // pipeline structs
  ////////////////////

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    mem_rd;
    logic    mem_wr;
    logic    reg_wr;
    wb_src_e wb_src;
  } ctrl_t;

  // everything execute needs from decode
  typedef struct packed {
    logic                  valid;
    ctrl_t                 ctrl;
    logic [ADDR_WIDTH-1:0] rd;
    logic [ADDR_WIDTH-1:0] rs1;
    logic [ADDR_WIDTH-1:0] rs2;
    logic [WORD-1:0]       imm;
    logic [WORD-1:0]       op_a;
    logic [WORD-1:0]       op_b;
    logic [WORD-1:0]       pc;
  } id_ex_t;

endpackage

//--- decode_exe_reg.sv
`timescale 1ns/100ps

module decode_exe_reg import cpu_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   bubble_i,
  input  logic   flush_i,
  input  id_ex_t id_ex_i,
  output id_ex_t id_ex_o
);

  logic   kill;
  logic   valid_q;
  logic   mem_rd_q;
  logic   mem_wr_q;
  logic   reg_wr_q;
  id_ex_t data_q;

  // stall, flush or an empty slot all turn into a bubble
  assign kill = bubble_i || flush_i || !id_ex_i.valid;

  // valid and enables
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      mem_rd_q <= 1'b0;
      mem_wr_q <= 1'b0;
      reg_wr_q <= 1'b0;
    end else begin
      valid_q  <= !kill;
      mem_rd_q <= !kill && id_ex_i.ctrl.mem_rd;
      mem_wr_q <= !kill && id_ex_i.ctrl.mem_wr;
      reg_wr_q <= !kill && id_ex_i.ctrl.reg_wr;
    end
  end

  // payload loads every cycle, a bubble just leaves it meaningless
  always_ff @(posedge clk_i) begin
    data_q <= id_ex_i;
  end

  always_comb begin
    id_ex_o             = data_q;
    id_ex_o.valid       = valid_q;
    id_ex_o.ctrl.mem_rd = mem_rd_q;
    id_ex_o.ctrl.mem_wr = mem_wr_q;
    id_ex_o.ctrl.reg_wr = reg_wr_q;
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // fetch
  input  logic                  instr_valid_i,
  input  logic [WORD-1:0]       instr_i,
  input  logic [WORD-1:0]       pc_i,
  output logic                  stall_o,
  // execute
  input  logic                  exe_mem_rd_i,
  input  logic [ADDR_WIDTH-1:0] exe_rd_i,
  // write-back
  input  logic                  wb_we_i,
  input  logic [ADDR_WIDTH-1:0] wb_addr_i,
  input  logic [WORD-1:0]       wb_data_i,
  // later stages
  input  logic                  flush_i,
  output id_ex_t                id_ex_o
);

  ctrl_t                 ctrl;
  logic [ADDR_WIDTH-1:0] rs1;
  logic [ADDR_WIDTH-1:0] rs2;
  logic [ADDR_WIDTH-1:0] rd;
  logic                  uses_rs2;
  logic [WORD-1:0]       imm;
  logic                  hazard;
  logic [WORD-1:0]       rdata_a;
  logic [WORD-1:0]       rdata_b;
  logic [WORD-1:0]       op_b;
  id_ex_t                id_ex_next;

  cpu_controller controller_inst (
    .instr_i    (instr_i),
    .ctrl_o     (ctrl),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rd_o       (rd),
    .uses_rs2_o (uses_rs2),
    .imm_o      (imm)
  );

  hazard_detector hazard_inst (
    .exe_mem_rd_i (exe_mem_rd_i),
    .exe_rd_i     (exe_rd_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .uses_rs2_i   (uses_rs2),
    .hazard_o     (hazard)
  );

  reg_file reg_file_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (wb_we_i),
    .waddr_i   (wb_addr_i),
    .wdata_i   (wb_data_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  // an empty slot never holds fetch
  assign stall_o = instr_valid_i && hazard;

  // stores keep their data in op_b, the offset rides along in imm
  assign op_b = (ctrl.alu_src_imm && !ctrl.mem_wr) ? imm : rdata_b;

  always_comb begin
    id_ex_next.valid = instr_valid_i;
    id_ex_next.ctrl  = ctrl;
    id_ex_next.rd    = rd;
    id_ex_next.rs1   = rs1;
    id_ex_next.rs2   = rs2;
    id_ex_next.imm   = imm;
    id_ex_next.op_a  = rdata_a;
    id_ex_next.op_b  = op_b;
    id_ex_next.pc    = pc_i;
  end

  decode_exe_reg id_ex_reg_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .bubble_i (stall_o),
    .flush_i  (flush_i),
    .id_ex_i  (id_ex_next),
    .id_ex_o  (id_ex_o)
  );

endmodule

//--- decode_stage_chk.sv
`timescale 1ns/100ps

module decode_stage_chk import cpu_pkg::*; (
  input logic   clk_i,
  input logic   rst_n_i,
  input logic   instr_valid_i,
  input logic   stall_i,
  input logic   flush_i,
  input id_ex_t id_ex_i
);

  // an empty slot must not touch memory or the register file
  idle_slot_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !id_ex_i.valid |-> !(id_ex_i.ctrl.mem_rd || id_ex_i.ctrl.mem_wr || id_ex_i.ctrl.reg_wr))
    else $error("ctrl enable set while id_ex_o.valid is low");

  stall_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> !id_ex_i.valid)
    else $error("stall was not followed by a bubble");

  flush_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !id_ex_i.valid)
    else $error("flush was not followed by a bubble");

  stall_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |-> instr_valid_i)
    else $error("stall raised without a valid instruction");

endmodule

bind decode_stage decode_stage_chk decode_stage_chk_inst (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .instr_valid_i (instr_valid_i),
  .stall_i       (stall_o),
  .flush_i       (flush_i),
  .id_ex_i       (id_ex_o)
);

//--- decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb import cpu_pkg::*; ();

  localparam int RESET_LEN = 15;
  localparam int RW_LEN    = 40;
  localparam int DEC_LEN   = 60;
  localparam int HAZ_LEN   = 40;
  localparam int FLUSH_LEN = 40;
  // every test after reset drains its last check with one idle cycle
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_LEN + RW_LEN + DEC_LEN + HAZ_LEN + FLUSH_LEN + 5) + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  logic [WORD-1:0]       instr;
  logic [WORD-1:0]       pc;
  logic                  stall;
  logic                  exe_mem_rd;
  logic [ADDR_WIDTH-1:0] exe_rd;
  logic                  wb_we;
  logic [ADDR_WIDTH-1:0] wb_addr;
  logic [WORD-1:0]       wb_data;
  logic                  flush;
  id_ex_t                id_ex;

  // reference state
  logic [WORD-1:0] shadow [NUM_REGS];
  id_ex_t          exp;
  logic            exp_pending;
  logic            exp_stall;
  logic            exp_valid;
  int              seed   = 29686;
  int              checks = 0;
  int              errors = 0;
  int              cycles = 0;

  decode_stage decode_stage_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .stall_o       (stall),
    .exe_mem_rd_i  (exe_mem_rd),
    .exe_rd_i      (exe_rd),
    .wb_we_i       (wb_we),
    .wb_addr_i     (wb_addr),
    .wb_data_i     (wb_data),
    .flush_i       (flush),
    .id_ex_o       (id_ex)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic rand_bit();
    return 1'($random(seed));
  endfunction

  function automatic ctrl_t model_ctrl(input logic [3:0] op);
    ctrl_t c;
    c = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0, WB_ALU};
    case (op)
      4'h1: c.reg_wr = 1'b1;
      4'h2: c = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU};
      4'h3: c = '{ALU_AND, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU};
      4'h4: c = '{ALU_OR, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU};
      4'h5: c = '{ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU};
      4'h6: c = '{ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b1, WB_ALU};
      4'h7: c = '{ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b1, WB_MEM};
      4'h8: c = '{ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b0, WB_ALU};
      default: c.reg_wr = 1'b0;
    endcase
    return c;
  endfunction

  // a write-back in the same cycle is seen by the read
  function automatic logic [WORD-1:0] read_model(input logic [ADDR_WIDTH-1:0] a);
    return (wb_we && wb_addr == a) ? wb_data : shadow[a];
  endfunction

  task automatic check_value(input string name, input logic [WORD-1:0] got,
                             input logic [WORD-1:0] want);
    checks++;
    assert (got === want) else begin
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, want, got);
      errors++;
    end
  endtask

  task automatic check_outputs();
    if (!exp_pending) return;
    check_value("stall_o", stall, exp_stall);
    check_value("id_ex_o.valid", id_ex.valid, exp_valid);
    check_value("id_ex_o.ctrl.mem_rd", id_ex.ctrl.mem_rd, exp_valid && exp.ctrl.mem_rd);
    check_value("id_ex_o.ctrl.mem_wr", id_ex.ctrl.mem_wr, exp_valid && exp.ctrl.mem_wr);
    check_value("id_ex_o.ctrl.reg_wr", id_ex.ctrl.reg_wr, exp_valid && exp.ctrl.reg_wr);
    if (exp_valid) begin
      check_value("id_ex_o.ctrl.alu_op", id_ex.ctrl.alu_op, exp.ctrl.alu_op);
      check_value("id_ex_o.ctrl.alu_src_imm", id_ex.ctrl.alu_src_imm, exp.ctrl.alu_src_imm);
      check_value("id_ex_o.ctrl.wb_src", id_ex.ctrl.wb_src, exp.ctrl.wb_src);
      check_value("id_ex_o.rd", id_ex.rd, exp.rd);
      check_value("id_ex_o.rs1", id_ex.rs1, exp.rs1);
      check_value("id_ex_o.rs2", id_ex.rs2, exp.rs2);
      check_value("id_ex_o.imm", id_ex.imm, exp.imm);
      check_value("id_ex_o.op_a", id_ex.op_a, exp.op_a);
      check_value("id_ex_o.op_b", id_ex.op_b, exp.op_b);
      check_value("id_ex_o.pc", id_ex.pc, exp.pc);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // checks the previous cycle, then drives one cycle on the falling edge
  task automatic step(input logic v, input logic [WORD-1:0] ins, input logic ld,
                      input logic fl, input logic we);
    logic [3:0]            op;
    logic [ADDR_WIDTH-1:0] rb;
    logic                  use_b;
    @(negedge clk);
    check_outputs();
    // fetch holds its slot while stalled
    if (exp_stall) begin
      v   = instr_valid;
      ins = instr;
    end else begin
      pc = $random(seed);
    end
    instr_valid = v;
    instr       = ins;
    exe_mem_rd  = ld;
    exe_rd      = $random(seed);
    flush       = fl;
    wb_we       = we;
    wb_addr     = $random(seed);
    wb_data     = $random(seed);
    op    = ins[15:12];
    rb    = (op == 4'h8) ? ins[11:9] : ins[5:3];
    use_b = (op inside {[4'h1:4'h5], 4'h8});
    exp.ctrl  = model_ctrl(op);
    exp.rd    = ins[11:9];
    exp.rs1   = ins[8:6];
    exp.rs2   = rb;
    exp.imm   = {{(WORD-6){ins[5]}}, ins[5:0]};
    exp.op_a  = read_model(ins[8:6]);
    exp.op_b  = (op inside {4'h6, 4'h7}) ? exp.imm : read_model(rb);
    exp.pc    = pc;
    exp_stall = v && ld && (exe_rd == ins[8:6] || (use_b && exe_rd == rb));
    exp_valid = v && !exp_stall && !fl;
    exp_pending = 1'b1;
    if (we) shadow[wb_addr] = wb_data;
  endtask

  task automatic run_test(input string name, input int kind, input int len);
    int          errs_before;
    int          checks_before;
    logic [15:0] ins;
    errs_before   = errors;
    checks_before = checks;
    for (int i = 0; i < len; i++) begin
      ins = $random(seed);
      ins[15:12] = 4'($unsigned($random(seed)) % 9);
      case (kind)
        0: step(1'b1, {4'h1, 3'd0, i[2:0], ~i[2:0], 3'd0}, 1'b0, 1'b0, 1'b0);
        1: step(1'b1, {4'h1, ins[11:0]}, 1'b0, 1'b0, rand_bit());
        2: step(1'b1, ins, 1'b0, 1'b0, rand_bit());
        3: step(1'b1, ins, rand_bit(), 1'b0, rand_bit());
        default: step(rand_bit(), ins, 1'b0, rand_bit(), rand_bit());
      endcase
    end
    step(1'b0, 16'h0000, 1'b0, 1'b0, 1'b0);
    $display("test %s done: %0d checks, %0d errors", name,
             checks - checks_before, errors - errs_before);
  endtask

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    exe_mem_rd  = 1'b0;
    exe_rd      = '0;
    wb_we       = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    flush       = 1'b0;
    exp         = '0;
    exp_pending = 1'b0;
    exp_stall   = 1'b0;
    exp_valid   = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("id_ex_o.valid", id_ex.valid, 1'b0);
    check_value("id_ex_o.ctrl.mem_rd", id_ex.ctrl.mem_rd, 1'b0);
    check_value("id_ex_o.ctrl.mem_wr", id_ex.ctrl.mem_wr, 1'b0);
    check_value("id_ex_o.ctrl.reg_wr", id_ex.ctrl.reg_wr, 1'b0);
    run_test("reset", 0, NUM_REGS);
    run_test("write_read", 1, RW_LEN);
    run_test("decode", 2, DEC_LEN);
    run_test("load_use", 3, HAZ_LEN);
    run_test("flush", 4, FLUSH_LEN);
    @(negedge clk);
    check_outputs();
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
cpu_pkg.sv
cpu_controller.sv
hazard_detector.sv
reg_file.sv
decode_exe_reg.sv
decode_stage.sv
decode_stage_chk.sv
decode_stage_tb.sv

//--- hazard_detector.sv
`timescale 1ns/100ps

module hazard_detector import cpu_pkg::*; (
  input  logic                  exe_mem_rd_i,
  input  logic [ADDR_WIDTH-1:0] exe_rd_i,
  input  logic [ADDR_WIDTH-1:0] rs1_i,
  input  logic [ADDR_WIDTH-1:0] rs2_i,
  input  logic                  uses_rs2_i,
  output logic                  hazard_o
);

  logic rs1_hit;
  logic rs2_hit;

  // rs1 is always read as the base or first operand
  assign rs1_hit = (exe_rd_i == rs1_i);

  // second port only matters when the instruction reads it
  assign rs2_hit = uses_rs2_i && (exe_rd_i == rs2_i);

  // load result is not ready until after execute, so hold decode
  assign hazard_o = exe_mem_rd_i && (rs1_hit || rs2_hit);

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] waddr_i,
  input  logic [WORD-1:0]       wdata_i,
  input  logic [ADDR_WIDTH-1:0] raddr_a_i,
  input  logic [ADDR_WIDTH-1:0] raddr_b_i,
  output logic [WORD-1:0]       rdata_a_o,
  output logic [WORD-1:0]       rdata_b_o
);

  logic [WORD-1:0] regs_q [NUM_REGS];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////
  // read ports
  ////////////////////

  // same-cycle write-back goes straight through to the reader
  assign rdata_a_o = (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs_q[raddr_b_i];

endmodule
